//--- Bender.yml
package:
  name: dcache

export_include_dirs:
  - design

sources:
  - design/dcache_pkg.sv
  - design/dcache_ifs.sv
  - design/dcache_ram.sv
  - design/dcache_lookup.sv
  - design/dcache_miss_ctrl.sv
  - design/dcache_mem_port.sv
  - design/dcache_top.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/tb_dcache.sv

//--- build.f
+incdir+design
design/dcache_pkg.sv
design/dcache_ifs.sv
design/dcache_ram.sv
design/dcache_lookup.sv
design/dcache_miss_ctrl.sv
design/dcache_mem_port.sv
design/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

//--- design/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// byte address width
`define DCACHE_ADDR_W 32

// line geometry
`define DCACHE_WORD_PER_LINE 8

// associativity of 2 or 4 for the tree pseudo-LRU
`define DCACHE_WAYS 4

// sets per way
`define DCACHE_SETS 16

// derived address fields
`define DCACHE_OFFSET_W $clog2(`DCACHE_WORD_PER_LINE)
`define DCACHE_INDEX_W $clog2(`DCACHE_SETS)

// two byte bits below the word offset
`define DCACHE_TAG_W (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W - 2)

`endif

//--- design/dcache_ifs.sv
`timescale 1ns/1ps

interface lookup_miss_if;
	// lookup side
	logic miss;
	dcache_pkg::addr_t miss_addr;
	dcache_pkg::way_t victim_way;
	dcache_pkg::tag_entry_t victim_tag;
	// word of the way being read out
	dcache_pkg::word_t rd_data;

	// controller side
	logic stall;
	logic ram_busy;
	dcache_pkg::index_t rd_index;
	dcache_pkg::offset_t rd_offset;
	logic fill_we;
	dcache_pkg::way_t fill_way;
	dcache_pkg::index_t fill_index;
	dcache_pkg::offset_t fill_offset;
	dcache_pkg::word_t fill_data;
	logic tag_we;
	dcache_pkg::way_t tag_way;
	dcache_pkg::index_t tag_index;
	dcache_pkg::tag_entry_t tag_data;

	modport lookup (
		output miss, miss_addr, victim_way, victim_tag, rd_data,
		input stall, ram_busy, rd_index, rd_offset,
		input fill_we, fill_way, fill_index, fill_offset, fill_data,
		input tag_we, tag_way, tag_index, tag_data
	);

	modport ctrl (
		input miss, miss_addr, victim_way, victim_tag, rd_data,
		output stall, ram_busy, rd_index, rd_offset,
		output fill_we, fill_way, fill_index, fill_offset, fill_data,
		output tag_we, tag_way, tag_index, tag_data
	);
endinterface

interface ctrl_port_if;
	logic evict_we;
	dcache_pkg::offset_t evict_offset;
	dcache_pkg::word_t evict_data;
	dcache_pkg::addr_t evict_addr;
	logic wb_start;
	logic rd_start;
	dcache_pkg::addr_t rd_addr;

	logic wb_busy;
	logic beat_valid;
	dcache_pkg::offset_t beat_offset;
	dcache_pkg::word_t beat_data;
	logic beat_last;

	modport ctrl (
		output evict_we, evict_offset, evict_data, evict_addr, wb_start, rd_start, rd_addr,
		input wb_busy, beat_valid, beat_offset, beat_data, beat_last
	);

	modport port (
		input evict_we, evict_offset, evict_data, evict_addr, wb_start, rd_start, rd_addr,
		output wb_busy, beat_valid, beat_offset, beat_data, beat_last
	);
endinterface

//--- design/dcache_lookup.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_lookup (
	input logic i_clk,
	input logic i_rst,
	input logic i_valid,
	input dcache_pkg::addr_t i_addr,
	input dcache_pkg::byte_en_t i_wen,
	input dcache_pkg::word_t i_wdata,
	output logic o_valid,
	output dcache_pkg::word_t o_rdata,
	lookup_miss_if.lookup lk
);

	localparam int IDX_LSB = 2 + `DCACHE_OFFSET_W;
	localparam int DATA_AW = `DCACHE_INDEX_W + `DCACHE_OFFSET_W;

	function automatic dcache_pkg::word_t byte_merge(
		input dcache_pkg::word_t old_word,
		input dcache_pkg::word_t new_word,
		input dcache_pkg::byte_en_t be
	);
		dcache_pkg::word_t merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				merged[8*b +: 8] = new_word[8*b +: 8];
		end
		return merged;
	endfunction

	// bit 1 is the root for four ways and a 0 there points at ways 2 and 3
	function automatic dcache_pkg::way_t plru_victim(input dcache_pkg::plru_t bits);
		logic [2:0] t;
		t = 3'(bits);
		if (`DCACHE_WAYS == 2)
			return dcache_pkg::way_t'(~t[0]);
		if (t[1])
			return dcache_pkg::way_t'(t[0] ? 0 : 1);
		return dcache_pkg::way_t'(t[2] ? 2 : 3);
	endfunction

	function automatic dcache_pkg::plru_t plru_touch(
		input dcache_pkg::plru_t bits,
		input dcache_pkg::way_t way
	);
		logic [2:0] t;
		logic [1:0] w;
		t = 3'(bits);
		w = 2'(way);
		if (`DCACHE_WAYS == 2)
			return dcache_pkg::plru_t'(w[0]);
		case (w)
			2'd0: t = {t[2], 2'b00};
			2'd1: t = {t[2], 2'b01};
			2'd2: t = {2'b01, t[0]};
			default: t = {2'b11, t[0]};
		endcase
		return dcache_pkg::plru_t'(t);
	endfunction

	logic r_valid;
	logic r_pending;
	logic r_cmp_ok;
	dcache_pkg::addr_t r_addr;
	dcache_pkg::byte_en_t r_wen;
	dcache_pkg::word_t r_wdata;
	dcache_pkg::plru_t [`DCACHE_SETS-1:0] r_plru;

	dcache_pkg::addr_t w_look_addr;
	dcache_pkg::index_t w_rd_index;
	dcache_pkg::offset_t w_rd_offset;
	dcache_pkg::index_t w_req_index;
	dcache_pkg::offset_t w_req_offset;
	logic [DATA_AW-1:0] w_data_waddr;
	dcache_pkg::word_t w_data_wdata;
	dcache_pkg::tag_entry_t [`DCACHE_WAYS-1:0] w_tag_rd;
	dcache_pkg::word_t [`DCACHE_WAYS-1:0] w_data_rd;
	logic [`DCACHE_WAYS-1:0] w_way_hit;
	dcache_pkg::way_t w_hit_way;
	dcache_pkg::way_t w_victim;
	logic w_cmp;
	logic w_hit;
	logic w_store;

	// a held request re-reads its own set while stalled
	assign w_look_addr = lk.stall ? r_addr : i_addr;
	assign w_rd_index = lk.ram_busy ? lk.rd_index : w_look_addr[IDX_LSB +: `DCACHE_INDEX_W];
	assign w_rd_offset = lk.ram_busy ? lk.rd_offset : w_look_addr[2 +: `DCACHE_OFFSET_W];
	assign w_req_index = r_addr[IDX_LSB +: `DCACHE_INDEX_W];
	assign w_req_offset = r_addr[2 +: `DCACHE_OFFSET_W];

	assign w_cmp = r_valid && r_cmp_ok;
	assign w_hit = |w_way_hit;
	assign w_store = w_hit && (|r_wen);

	// refill and store never overlap since a store needs a hit
	assign w_data_waddr = lk.fill_we ? {lk.fill_index, lk.fill_offset} : {w_req_index, w_req_offset};
	assign w_data_wdata = lk.fill_we ? lk.fill_data : byte_merge(o_rdata, r_wdata, r_wen);

	for (genvar i = 0; i < `DCACHE_WAYS; i++) begin : gen_way
		// invalid entries come only from the sweep and clear every way
		dcache_ram #(
			.payload_t(dcache_pkg::tag_entry_t),
			.DEPTH(`DCACHE_SETS)
		) tag_ram_i (
			.i_clk(i_clk),
			.i_we(lk.tag_we && (!lk.tag_data.valid || lk.tag_way == i)),
			.i_waddr(lk.tag_index),
			.i_raddr(w_rd_index),
			.i_wdata(lk.tag_data),
			.o_rdata(w_tag_rd[i])
		);

		dcache_ram #(
			.payload_t(dcache_pkg::word_t),
			.DEPTH(`DCACHE_SETS * `DCACHE_WORD_PER_LINE)
		) data_ram_i (
			.i_clk(i_clk),
			.i_we(lk.fill_we ? (lk.fill_way == i) : (w_store && w_way_hit[i])),
			.i_waddr(w_data_waddr),
			.i_raddr({w_rd_index, w_rd_offset}),
			.i_wdata(w_data_wdata),
			.o_rdata(w_data_rd[i])
		);

		assign w_way_hit[i] = w_cmp && w_tag_rd[i].valid &&
			(w_tag_rd[i].tag == r_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W]);
	end

	always_comb begin
		w_hit_way = '0;
		for (int i = 0; i < `DCACHE_WAYS; i++) begin
			if (w_way_hit[i])
				w_hit_way = w_hit_way | dcache_pkg::way_t'(i);
		end
	end

	assign w_victim = plru_victim(r_plru[w_req_index]);

	assign o_valid = w_hit;
	assign o_rdata = w_data_rd[w_hit_way];

	// a held request misses once and its retry after refill hits
	assign lk.miss = w_cmp && !w_hit && !r_pending;
	assign lk.miss_addr = r_addr;
	assign lk.victim_way = w_victim;
	assign lk.victim_tag = w_tag_rd[w_victim];
	assign lk.rd_data = w_data_rd[lk.fill_way];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_valid <= 1'b0;
			r_pending <= 1'b0;
			r_cmp_ok <= 1'b0;
			r_plru <= '0;
		end else begin
			// ram outputs belong to the request stage unless read out for eviction
			r_cmp_ok <= !lk.ram_busy;
			if (!lk.stall)
				r_valid <= i_valid;
			if (lk.miss)
				r_pending <= 1'b1;
			else if (w_hit)
				r_pending <= 1'b0;
			if (w_hit)
				r_plru[w_req_index] <= plru_touch(r_plru[w_req_index], w_hit_way);
			else if (lk.miss)
				r_plru[w_req_index] <= plru_touch(r_plru[w_req_index], w_victim);
		end
	end

	always_ff @(posedge i_clk) begin
		if (!lk.stall && i_valid) begin
			r_addr <= i_addr;
			r_wen <= i_wen;
			r_wdata <= i_wdata;
		end
	end

	// a line is only ever filled into one way
	a_one_hit_way: assert property (@(posedge i_clk) disable iff (i_rst)
		$onehot0(w_way_hit));

endmodule

//--- design/dcache_mem_port.sv
`timescale 1ns/1ps

module dcache_mem_port (
	input logic i_clk,
	input logic i_rst,
	ctrl_port_if.port mp,
	output logic o_rd_req,
	output dcache_pkg::addr_t o_rd_addr,
	input logic i_rd_valid,
	input logic i_rd_last,
	input dcache_pkg::word_t i_rd_data,
	output logic o_wr_valid,
	output dcache_pkg::addr_t o_wr_addr,
	output dcache_pkg::line_t o_wr_line,
	input logic i_wr_done
);

	dcache_pkg::offset_t r_beat_cnt;
	// eviction line buffer
	dcache_pkg::line_t r_line;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_rd_req <= 1'b0;
			o_wr_valid <= 1'b0;
			r_beat_cnt <= '0;
		end else begin
			o_rd_req <= mp.rd_start;
			if (mp.wb_start)
				o_wr_valid <= 1'b1;
			else if (i_wr_done)
				o_wr_valid <= 1'b0;
			// beats arrive in address order
			if (i_rd_valid)
				r_beat_cnt <= i_rd_last ? '0 : r_beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (mp.rd_start)
			o_rd_addr <= mp.rd_addr;
		if (mp.evict_we)
			r_line[mp.evict_offset] <= mp.evict_data;
		if (mp.wb_start)
			o_wr_addr <= mp.evict_addr;
	end

	assign o_wr_line = r_line;

	// busy already in the start cycle so the refill waits for it
	assign mp.wb_busy = o_wr_valid || mp.wb_start;

	assign mp.beat_valid = i_rd_valid;
	assign mp.beat_offset = r_beat_cnt;
	assign mp.beat_data = i_rd_data;
	assign mp.beat_last = i_rd_last;

	// refill never overtakes the pending eviction
	a_no_read_during_write: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_rd_req && o_wr_valid));

endmodule

//--- design/dcache_miss_ctrl.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_miss_ctrl (
	input logic i_clk,
	input logic i_rst,
	lookup_miss_if.ctrl lk,
	ctrl_port_if.ctrl mp
);

	localparam int IDX_LSB = 2 + `DCACHE_OFFSET_W;

	typedef enum logic [2:0] {
		S_SWEEP,
		S_IDLE,
		S_EVICT_WAIT,
		S_EVICT_READ,
		S_WRITE_WAIT,
		S_REQUEST,
		S_RECEIVE
	} state_t;

	state_t r_state;
	state_t w_state;
	// top bit marks the settle cycle after the last set
	logic [`DCACHE_INDEX_W:0] r_sweep_cnt;
	dcache_pkg::offset_t r_rd_cnt;
	logic r_evict_we;
	dcache_pkg::offset_t r_evict_off;
	dcache_pkg::addr_t r_miss_addr;
	dcache_pkg::way_t r_way;
	dcache_pkg::tag_entry_t r_victim;
	dcache_pkg::index_t w_index;
	logic w_sweeping;
	logic w_fill_done;

	assign w_index = r_miss_addr[IDX_LSB +: `DCACHE_INDEX_W];
	assign w_sweeping = (r_state == S_SWEEP) && !r_sweep_cnt[`DCACHE_INDEX_W];
	assign w_fill_done = (r_state == S_RECEIVE) && mp.beat_valid && mp.beat_last;

	always_comb begin
		w_state = r_state;
		case (r_state)
			S_SWEEP: begin
				if (r_sweep_cnt[`DCACHE_INDEX_W])
					w_state = S_IDLE;
			end
			S_IDLE: begin
				// an invalid victim skips the read-out
				if (lk.miss)
					w_state = lk.victim_tag.valid ? S_EVICT_WAIT : S_WRITE_WAIT;
			end
			S_EVICT_WAIT: begin
				if (!mp.wb_busy)
					w_state = S_EVICT_READ;
			end
			S_EVICT_READ: begin
				if (r_rd_cnt == '1)
					w_state = S_WRITE_WAIT;
			end
			S_WRITE_WAIT: begin
				// refill only after the victim has reached memory
				if (!mp.wb_busy)
					w_state = S_REQUEST;
			end
			S_REQUEST: begin
				w_state = S_RECEIVE;
			end
			S_RECEIVE: begin
				if (w_fill_done)
					w_state = S_IDLE;
			end
			default: begin
				w_state = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= S_SWEEP;
			r_sweep_cnt <= '0;
			r_rd_cnt <= '0;
			r_evict_we <= 1'b0;
		end else begin
			r_state <= w_state;
			if (r_state == S_SWEEP)
				r_sweep_cnt <= r_sweep_cnt + 1'b1;
			if (r_state == S_EVICT_READ)
				r_rd_cnt <= r_rd_cnt + 1'b1;
			// ram data shows up one cycle after the read
			r_evict_we <= (r_state == S_EVICT_READ);
		end
	end

	always_ff @(posedge i_clk) begin
		r_evict_off <= r_rd_cnt;
		if ((r_state == S_IDLE) && lk.miss) begin
			r_miss_addr <= lk.miss_addr;
			r_way <= lk.victim_way;
			r_victim <= lk.victim_tag;
		end
	end

	assign lk.stall = (r_state != S_IDLE) || lk.miss;
	assign lk.ram_busy = (r_state == S_EVICT_READ);
	assign lk.rd_index = w_index;
	assign lk.rd_offset = r_rd_cnt;

	assign lk.fill_we = mp.beat_valid;
	assign lk.fill_way = r_way;
	assign lk.fill_index = w_index;
	assign lk.fill_offset = mp.beat_offset;
	assign lk.fill_data = mp.beat_data;

	assign lk.tag_we = w_sweeping || w_fill_done;
	assign lk.tag_way = r_way;
	assign lk.tag_index = w_sweeping ? r_sweep_cnt[`DCACHE_INDEX_W-1:0] : w_index;
	assign lk.tag_data = w_sweeping ? '0 :
		{1'b1, r_miss_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W]};

	assign mp.evict_we = r_evict_we;
	assign mp.evict_offset = r_evict_off;
	assign mp.evict_data = lk.rd_data;
	assign mp.evict_addr = {r_victim.tag, w_index, {IDX_LSB{1'b0}}};
	// start with the last word so the buffer is complete when the write shows
	assign mp.wb_start = r_evict_we && (r_evict_off == '1);
	assign mp.rd_start = (r_state == S_REQUEST);
	assign mp.rd_addr = {r_miss_addr[`DCACHE_ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};

	// memory sends beats only for a request it was given
	a_fill_in_receive: assert property (@(posedge i_clk) disable iff (i_rst)
		lk.fill_we |-> (r_state == S_RECEIVE));

endmodule

//--- design/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

	// data word as seen by the core
	typedef logic [31:0] word_t;

	// byte address
	typedef logic [`DCACHE_ADDR_W-1:0] addr_t;

	// one enable per byte lane
	typedef logic [3:0] byte_en_t;

	// tag ram entry
	typedef struct packed {
		logic valid;
		logic [`DCACHE_TAG_W-1:0] tag;
	} tag_entry_t;

	// a whole line, word 0 at the lowest address
	typedef word_t [`DCACHE_WORD_PER_LINE-1:0] line_t;

	typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

	typedef logic [`DCACHE_INDEX_W-1:0] index_t;

	typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

	// tree bits of one set
	typedef logic [`DCACHE_WAYS-2:0] plru_t;

endpackage

//--- design/dcache_ram.sv
`timescale 1ns/1ps

module dcache_ram #(
	parameter type payload_t = logic,
	parameter int DEPTH = 16
) (
	input logic i_clk,
	input logic i_we,
	input logic [$clog2(DEPTH)-1:0] i_waddr,
	input logic [$clog2(DEPTH)-1:0] i_raddr,
	input payload_t i_wdata,
	output payload_t o_rdata
);

	payload_t mem [DEPTH];

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
		// same-address write is forwarded to the read port
		if (i_we && (i_waddr == i_raddr)) begin
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= mem[i_raddr];
		end
	end

endmodule

//--- design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
	input logic i_clk,
	input logic i_rst,
	input logic i_valid,
	input dcache_pkg::addr_t i_addr,
	input dcache_pkg::byte_en_t i_wen,
	input dcache_pkg::word_t i_wdata,
	output logic o_stall,
	output logic o_valid,
	output dcache_pkg::word_t o_rdata,
	output logic o_rd_req,
	output dcache_pkg::addr_t o_rd_addr,
	input logic i_rd_valid,
	input dcache_pkg::word_t i_rd_data,
	input logic i_rd_last,
	output logic o_wr_valid,
	output dcache_pkg::addr_t o_wr_addr,
	output dcache_pkg::line_t o_wr_line,
	input logic i_wr_done
);

	lookup_miss_if lk_if ();
	ctrl_port_if mp_if ();

	assign o_stall = lk_if.stall;

	dcache_lookup lookup_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_valid(i_valid),
		.i_addr(i_addr),
		.i_wen(i_wen),
		.i_wdata(i_wdata),
		.o_valid(o_valid),
		.o_rdata(o_rdata),
		.lk(lk_if.lookup)
	);

	dcache_miss_ctrl miss_ctrl_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.lk(lk_if.ctrl),
		.mp(mp_if.ctrl)
	);

	dcache_mem_port mem_port_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.mp(mp_if.port),
		.o_rd_req(o_rd_req),
		.o_rd_addr(o_rd_addr),
		.i_rd_valid(i_rd_valid),
		.i_rd_last(i_rd_last),
		.i_rd_data(i_rd_data),
		.o_wr_valid(o_wr_valid),
		.o_wr_addr(o_wr_addr),
		.o_wr_line(o_wr_line),
		.i_wr_done(i_wr_done)
	);

endmodule

//--- tests/mem_model.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module mem_model (
	input logic i_clk,
	input logic i_rd_req,
	input dcache_pkg::addr_t i_rd_addr,
	output logic o_rd_valid,
	output dcache_pkg::word_t o_rd_data,
	output logic o_rd_last,
	input logic i_wr_valid,
	input dcache_pkg::addr_t i_wr_addr,
	input dcache_pkg::line_t i_wr_line,
	output logic o_wr_done
);

	localparam int MEM_BYTES = 65536;

	// only the low 64 KB are backed
	logic [7:0] mem [MEM_BYTES];

	function automatic dcache_pkg::word_t fill_word(input dcache_pkg::addr_t a);
		return (a * 32'h9e37_79b1) ^ (a >> 7);
	endfunction

	function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t a);
		int base;
		base = int'(a[15:0]);
		return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
	endfunction

	initial begin
		dcache_pkg::word_t w;
		for (int i = 0; i < MEM_BYTES; i += 4) begin
			w = fill_word(dcache_pkg::addr_t'(i));
			for (int b = 0; b < 4; b++)
				mem[i + b] = w[8*b +: 8];
		end
	end

	// refill beats in address order with random gaps
	initial begin
		dcache_pkg::addr_t base;
		o_rd_valid = 1'b0;
		o_rd_data = '0;
		o_rd_last = 1'b0;
		forever begin
			@(negedge i_clk);
			if (i_rd_req) begin
				base = i_rd_addr;
				repeat ($urandom_range(1, 4)) @(posedge i_clk);
				for (int n = 0; n < `DCACHE_WORD_PER_LINE; n++) begin
					if (n != 0 && $urandom_range(0, 2) == 0) begin
						#1;
						o_rd_valid = 1'b0;
						@(posedge i_clk);
					end
					#1;
					o_rd_valid = 1'b1;
					o_rd_data = read_word(base + dcache_pkg::addr_t'(4 * n));
					o_rd_last = (n == `DCACHE_WORD_PER_LINE - 1);
					@(posedge i_clk);
				end
				#1;
				o_rd_valid = 1'b0;
				o_rd_last = 1'b0;
			end
		end
	end

	// writeback lines land after a random delay
	initial begin
		int base;
		o_wr_done = 1'b0;
		forever begin
			@(negedge i_clk);
			if (i_wr_valid) begin
				repeat ($urandom_range(1, 4)) @(posedge i_clk);
				#1;
				base = int'(i_wr_addr[15:0]);
				for (int w = 0; w < `DCACHE_WORD_PER_LINE; w++) begin
					for (int b = 0; b < 4; b++)
						mem[base + 4*w + b] = i_wr_line[w][8*b +: 8];
				end
				o_wr_done = 1'b1;
				@(posedge i_clk);
				#1;
				o_wr_done = 1'b0;
			end
		end
	end

endmodule

//--- tests/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_dcache;

	localparam int N_RAND = 300;
	// directed part stays below 40 requests
	localparam int N_REQ = 40 + N_RAND;
	localparam int SHADOW_WORDS = 16384;
	localparam int SET_STRIDE = `DCACHE_SETS * `DCACHE_WORD_PER_LINE * 4;
	localparam dcache_pkg::addr_t LINE_A = 32'h0000_1000;
	localparam dcache_pkg::addr_t BASE_RAND = 32'h0000_8000;

	typedef struct packed {
		dcache_pkg::addr_t addr;
		dcache_pkg::byte_en_t wen;
		dcache_pkg::word_t exp;
		int cyc;
		logic hit;
	} req_t;

	logic clk;
	logic rst;
	logic valid;
	dcache_pkg::addr_t addr;
	dcache_pkg::byte_en_t wen;
	dcache_pkg::word_t wdata;
	logic stall;
	logic rvalid;
	dcache_pkg::word_t rdata;
	logic rd_req;
	dcache_pkg::addr_t rd_addr;
	logic rd_valid;
	dcache_pkg::word_t rd_data;
	logic rd_last;
	logic wr_valid;
	dcache_pkg::addr_t wr_addr;
	dcache_pkg::line_t wr_line;
	logic wr_done;

	dcache_pkg::word_t shadow [SHADOW_WORDS];
	req_t pend [$];
	req_t cur;
	int cyc = 0;
	int n_acc = 0;
	int rd_count = 0;
	int wb_count = 0;
	logic wr_prev = 1'b0;
	dcache_pkg::addr_t rd_addr_seen;
	dcache_pkg::addr_t wb_addr_seen;

	dcache_top dut_i (
		.i_clk(clk), .i_rst(rst), .i_valid(valid), .i_addr(addr), .i_wen(wen),
		.i_wdata(wdata), .o_stall(stall), .o_valid(rvalid), .o_rdata(rdata),
		.o_rd_req(rd_req), .o_rd_addr(rd_addr), .i_rd_valid(rd_valid),
		.i_rd_data(rd_data), .i_rd_last(rd_last), .o_wr_valid(wr_valid),
		.o_wr_addr(wr_addr), .o_wr_line(wr_line), .i_wr_done(wr_done)
	);

	mem_model mem_i (
		.i_clk(clk), .i_rd_req(rd_req), .i_rd_addr(rd_addr), .o_rd_valid(rd_valid),
		.o_rd_data(rd_data), .o_rd_last(rd_last), .i_wr_valid(wr_valid),
		.i_wr_addr(wr_addr), .i_wr_line(wr_line), .o_wr_done(wr_done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	function automatic dcache_pkg::word_t fill_word(input dcache_pkg::addr_t a);
		return (a * 32'h9e37_79b1) ^ (a >> 7);
	endfunction

	// expected word after merging the store bytes into the shadow
	function automatic dcache_pkg::word_t ref_word(input dcache_pkg::addr_t a,
		input dcache_pkg::byte_en_t be, input dcache_pkg::word_t d);
		dcache_pkg::word_t w;
		w = shadow[a[15:2]];
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				w[8*b +: 8] = d[8*b +: 8];
		end
		return w;
	endfunction

	task automatic check_word(input dcache_pkg::word_t got, input dcache_pkg::word_t exp,
		input dcache_pkg::addr_t a);
		if (got !== exp)
			fail_run($sformatf("error at %0t ns: load from %h returned %h, expected %h",
				$time, a, got, exp));
	endtask

	task automatic check_line(input dcache_pkg::addr_t a, input dcache_pkg::line_t l);
		dcache_pkg::word_t exp;
		for (int w = 0; w < `DCACHE_WORD_PER_LINE; w++) begin
			exp = ref_word(a + dcache_pkg::addr_t'(4 * w), '0, '0);
			if (l[w] !== exp)
				fail_run($sformatf("error at %0t ns: writeback %h word %0d is %h, expected %h",
					$time, a, w, l[w], exp));
		end
	endtask

	task automatic check_addr(input dcache_pkg::addr_t got, input dcache_pkg::addr_t exp,
		input string what);
		if (got !== exp)
			fail_run($sformatf("error at %0t ns: %s address %h, expected %h",
				$time, what, got, exp));
	endtask

	// hold the request until the cache takes it, then log it in acceptance order
	task automatic issue(input dcache_pkg::addr_t a, input dcache_pkg::byte_en_t be,
		input dcache_pkg::word_t d, input logic hit);
		req_t r;
		valid = 1'b1;
		addr = a;
		wen = be;
		wdata = d;
		@(negedge clk);
		while (stall)
			@(negedge clk);
		@(posedge clk);
		#1;
		r.addr = a;
		r.wen = be;
		r.exp = ref_word(a, be, d);
		r.cyc = cyc;
		r.hit = hit;
		shadow[a[15:2]] = r.exp;
		pend.push_back(r);
		n_acc++;
		valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (pend.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	// response, refill and writeback monitor
	always @(negedge clk) begin
		if (!rst) begin
			if (rvalid) begin
				if (pend.size() == 0)
					fail_run("o_valid came with no request outstanding");
				cur = pend.pop_front();
				if (cur.hit && cyc != cur.cyc)
					fail_run($sformatf("error at %0t ns: hit on %h answered late",
						$time, cur.addr));
				if (cur.wen == '0)
					check_word(rdata, cur.exp, cur.addr);
			end
			if (rd_req) begin
				if (n_acc == 0)
					fail_run("a refill read appeared before the first access");
				rd_count++;
				rd_addr_seen = rd_addr;
			end
			if (wr_valid && !wr_prev) begin
				if (n_acc == 0)
					fail_run("a writeback appeared before the first access");
				wb_count++;
				wb_addr_seen = wr_addr;
				check_line(wr_addr, wr_line);
			end
			wr_prev = wr_valid;
		end
	end

	initial begin
		repeat (200 * N_REQ + `DCACHE_SETS + 16) @(posedge clk);
		fail_run("watchdog expired, the cache stopped answering requests");
	end

	initial begin
		int stall_cycles;
		int rd_before;
		int wb_before;
		logic ok;
		dcache_pkg::addr_t a;
		void'($urandom(26));
		rst = 1'b1;
		valid = 1'b0;
		addr = '0;
		wen = '0;
		wdata = '0;
		for (int i = 0; i < SHADOW_WORDS; i++)
			shadow[i] = fill_word(dcache_pkg::addr_t'(4 * i));
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// tag sweep after reset
		stall_cycles = 0;
		@(negedge clk);
		while (stall) begin
			stall_cycles++;
			@(negedge clk);
		end
		if (stall_cycles < `DCACHE_SETS)
			fail_run($sformatf("stall after reset lasted only %0d cycles", stall_cycles));
		@(posedge clk);
		#1;

		// first load, one refill at the line address
		rd_before = rd_count;
		issue(LINE_A + 4, '0, '0, 1'b0);
		wait_idle();
		if (rd_count != rd_before + 1)
			fail_run("the first load did not issue exactly one refill read");
		check_addr(rd_addr_seen, LINE_A, "refill");

		// back to back hits in the resident line
		rd_before = rd_count;
		wb_before = wb_count;
		for (int i = 0; i < `DCACHE_WORD_PER_LINE; i++) begin
			issue(LINE_A + dcache_pkg::addr_t'(4 * i), 4'hf, $urandom, 1'b1);
			issue(LINE_A + dcache_pkg::addr_t'(4 * i), '0, '0, 1'b1);
		end

		// partial byte stores
		issue(LINE_A + 8, 4'b0101, 32'ha1b2_c3d4, 1'b1);
		issue(LINE_A + 8, 4'b1000, 32'h1122_3344, 1'b1);
		issue(LINE_A + 8, '0, '0, 1'b1);
		issue(LINE_A + 20, 4'b0010, 32'hdead_beef, 1'b1);
		issue(LINE_A + 20, '0, '0, 1'b1);
		wait_idle();
		if (rd_count != rd_before || wb_count != wb_before)
			fail_run("a hit on a resident line went to memory");

		// one line more than the ways of a set
		wb_before = wb_count;
		for (int k = 1; k <= `DCACHE_WAYS; k++)
			issue(LINE_A + dcache_pkg::addr_t'(k * SET_STRIDE), '0, '0, 1'b0);
		wait_idle();
		if (wb_count != wb_before + 1)
			fail_run("filling one set past its ways did not cause exactly one writeback");
		ok = 1'b0;
		for (int k = 0; k < `DCACHE_WAYS - 1; k++) begin
			if (wb_addr_seen == LINE_A + dcache_pkg::addr_t'(k * SET_STRIDE))
				ok = 1'b1;
		end
		if (!ok)
			fail_run($sformatf("writeback of %h is not an older line of the set", wb_addr_seen));
		issue(wb_addr_seen + 12, '0, '0, 1'b0);
		wait_idle();

		// random loads and stores over 4 KB
		for (int n = 0; n < N_RAND; n++) begin
			a = BASE_RAND + dcache_pkg::addr_t'(4 * $urandom_range(0, 1023));
			if ($urandom_range(0, 1) == 0)
				issue(a, '0, '0, 1'b0);
			else
				issue(a, dcache_pkg::byte_en_t'($urandom_range(1, 15)), $urandom, 1'b0);
		end
		wait_idle();
		repeat (4) @(posedge clk);
		$display("No errors");
		$finish;
	end

endmodule
